// File: hdl/hmr_pkg.sv
// ##########################################################################
// Shared definitions for the DMR lane wrapper: widths, lane opcodes,
// the command union, lane result and register-bus structs
// ##########################################################################

`default_nettype none

package hmr_pkg;

  // Register file and datapath widths
  localparam int unsigned reg_addr_w = 3;
  localparam int unsigned data_w     = 32;
  localparam int unsigned num_regs   = 2 ** reg_addr_w;

  typedef enum logic [1:0] {
    OP_LI     = 2'd0,
    OP_ADD    = 2'd1,
    OP_XOR    = 2'd2,
    OP_HARTID = 2'd3
  } opcode_e;

  // Two-source format for add and xor
  typedef struct packed {
    opcode_e               opcode;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [4:0]            pad;
  } instr_r_t;

  // Immediate format with a zero-extended imm
  typedef struct packed {
    opcode_e               opcode;
    logic [reg_addr_w-1:0] rd;
    logic [10:0]           imm;
  } instr_i_t;

  // Same 16-bit command word seen through either format
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } lane_instr_u;

  typedef struct packed {
    logic        valid;
    lane_instr_u instr;
  } lane_cmd_t;

  // Also used as the backup write record
  typedef struct packed {
    logic                  valid;
    logic [reg_addr_w-1:0] rd;
    logic [data_w-1:0]     data;
  } lane_result_t;

  typedef logic [num_regs-1:0][data_w-1:0] rf_image_t;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [7:0]  addr;
    logic [31:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        error;
  } reg_rsp_t;

  localparam logic [31:0] err_value      = 32'hBADCAB1E;
  localparam logic [7:0]  cfg_addr_mode  = 8'h00;
  localparam logic [7:0]  cfg_addr_count = 8'h04;

endpackage

`default_nettype wire

// File: hdl/hmr_core_lane.sv
// ##########################################################################
// One compute lane: 8 x 32 register file, small ALU, registered result
// and whole-file load for rapid recovery
// ##########################################################################

`timescale 1ns/10ps
`default_nettype none

module hmr_core_lane
  import hmr_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,
  input  lane_cmd_t         cmd_i,
  input  logic [data_w-1:0] hart_id_i,
  input  logic              fault_i,
  input  logic              restore_i,
  input  rf_image_t         restore_image_i,
  output lane_result_t      result_o
);

  rf_image_t         rf_q;
  logic [data_w-1:0] op_a;
  logic [data_w-1:0] op_b;
  logic [data_w-1:0] alu_res;
  logic [data_w-1:0] wdata;

  // Operand read uses the r-format view of the command
  assign op_a = rf_q[cmd_i.instr.r.rs1];
  assign op_b = rf_q[cmd_i.instr.r.rs2];

  always_comb begin
    case (cmd_i.instr.r.opcode)
      OP_LI:   alu_res = data_w'(cmd_i.instr.i.imm);
      OP_ADD:  alu_res = op_a + op_b;
      OP_XOR:  alu_res = op_a ^ op_b;
      default: alu_res = hart_id_i;
    endcase
  end

  // Injected fault flips the LSB of the written value
  assign wdata = alu_res ^ data_w'(fault_i);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rf_q <= '0;
    end else if (restore_i) begin
      // Recovery wins over a write in the same cycle
      rf_q <= restore_image_i;
    end else if (cmd_i.valid) begin
      rf_q[cmd_i.instr.r.rd] <= wdata;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      result_o <= '0;
    end else begin
      result_o.valid <= cmd_i.valid & ~restore_i;
      if (cmd_i.valid) begin
        result_o.rd   <= cmd_i.instr.r.rd;
        result_o.data <= wdata;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/hmr_input_dist.sv
// ##########################################################################
// Input distributor: per-lane hart id and DMR command broadcast
// ##########################################################################

`timescale 1ns/10ps
`default_nettype none

module hmr_input_dist
  import hmr_pkg::*;
#(
  parameter int unsigned num_lanes = 4
) (
  input  logic                                dmr_mode_i,
  input  logic      [data_w-1:0]              hart_base_i,
  input  lane_cmd_t [num_lanes-1:0]           cmd_i,
  output lane_cmd_t [num_lanes-1:0]           lane_cmd_o,
  output logic      [num_lanes-1:0][data_w-1:0] lane_hart_id_o
);

  for (genvar i = 0; i < num_lanes; i++) begin : gen_dist
    if (i % 2 == 0) begin : gen_lead
      // Even lane leads its pair and always runs its own command
      assign lane_cmd_o[i]     = cmd_i[i];
      assign lane_hart_id_o[i] = hart_base_i + data_w'(i);
    end else begin : gen_follow
      logic [data_w-1:0] lane_offset;

      // Odd lane takes over its even partner in DMR mode
      assign lane_offset = dmr_mode_i ? data_w'(i - 1) : data_w'(i);

      assign lane_cmd_o[i]     = dmr_mode_i ? cmd_i[i - 1] : cmd_i[i];
      assign lane_hart_id_o[i] = hart_base_i + lane_offset;
    end
  end

endmodule

`default_nettype wire

// File: hdl/hmr_checker.sv
// ##########################################################################
// DMR checker: pair comparison, backup register file per pair,
// rapid recovery strobe and registered output selection
// ##########################################################################

`timescale 1ns/10ps
`default_nettype none

module hmr_checker
  import hmr_pkg::*;
#(
  parameter int unsigned num_lanes = 4
) (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                               dmr_mode_i,
  input  lane_result_t [num_lanes-1:0]       lane_result_i,
  output logic         [num_lanes/2-1:0]     restore_o,
  output rf_image_t    [num_lanes/2-1:0]     restore_image_o,
  output lane_result_t [num_lanes-1:0]       result_o,
  output logic         [num_lanes/2-1:0]     dmr_error_o,
  output logic         [num_lanes/2-1:0]     mismatch_o
);

  localparam int unsigned num_pairs = num_lanes / 2;

  for (genvar p = 0; p < num_pairs; p++) begin : gen_pair
    lane_result_t res_even;
    lane_result_t res_odd;
    lane_result_t out_even_q;
    lane_result_t out_odd_q;
    rf_image_t    backup_q;
    logic         restore_q;
    logic         error_q;
    logic         mismatch;
    logic         agree_wr;
    logic         check_en;

    assign res_even = lane_result_i[2*p];
    assign res_odd  = lane_result_i[2*p+1];

    // Results arriving while the lanes reload belong to a dropped command
    assign check_en = dmr_mode_i & ~restore_q;

    assign mismatch = check_en & (res_even.valid | res_odd.valid) & (res_even != res_odd);
    assign agree_wr = check_en & res_even.valid & (res_even == res_odd);

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        restore_q <= 1'b0;
        error_q   <= 1'b0;
        backup_q  <= '0;
      end else begin
        restore_q <= mismatch;
        error_q   <= mismatch;
        // Only the last agreeing state is kept
        if (agree_wr) begin
          backup_q[res_even.rd] <= res_even.data;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        out_even_q <= '0;
        out_odd_q  <= '0;
      end else if (dmr_mode_i) begin
        out_even_q       <= res_even;
        out_even_q.valid <= agree_wr;
        out_odd_q        <= '0;
      end else begin
        out_even_q <= res_even;
        out_odd_q  <= res_odd;
      end
    end

    assign restore_o[p]       = restore_q;
    assign restore_image_o[p] = backup_q;
    assign dmr_error_o[p]     = error_q;
    assign mismatch_o[p]      = mismatch;
    assign result_o[2*p]      = out_even_q;
    assign result_o[2*p+1]    = out_odd_q;
  end

endmodule

`default_nettype wire

// File: hdl/hmr_cfg_regs.sv
// ##########################################################################
// Configuration registers: DMR mode, mismatch counter and
// error response on unmapped addresses
// ##########################################################################

`timescale 1ns/10ps
`default_nettype none

module hmr_cfg_regs
  import hmr_pkg::*;
#(
  parameter int unsigned num_lanes = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  reg_req_t               reg_req_i,
  input  logic [num_lanes/2-1:0] mismatch_i,
  output reg_rsp_t               reg_rsp_o,
  output logic                   dmr_mode_o
);

  localparam int unsigned num_pairs = num_lanes / 2;
  localparam int unsigned sum_w     = $clog2(num_pairs + 1);

  logic             mode_q;
  logic [15:0]      count_q;
  logic [16:0]      count_sum;
  logic [sum_w-1:0] mismatch_cnt;

  // Number of pairs that mismatched this cycle
  always_comb begin
    mismatch_cnt = '0;
    for (int i = 0; i < num_pairs; i++) begin
      mismatch_cnt = mismatch_cnt + sum_w'(mismatch_i[i]);
    end
  end

  assign count_sum = {1'b0, count_q} + 17'(mismatch_cnt);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mode_q  <= 1'b0;
      count_q <= '0;
    end else begin
      if (reg_req_i.valid && reg_req_i.write && reg_req_i.addr == cfg_addr_mode) begin
        mode_q <= reg_req_i.wdata[0];
      end
      // Saturates at all ones
      count_q <= count_sum[16] ? 16'hFFFF : count_sum[15:0];
    end
  end

  always_comb begin
    reg_rsp_o = '0;
    if (reg_req_i.valid) begin
      case (reg_req_i.addr)
        cfg_addr_mode:  reg_rsp_o.rdata = {31'b0, mode_q};
        cfg_addr_count: reg_rsp_o.rdata = {16'b0, count_q};
        default: begin
          reg_rsp_o.rdata = err_value;
          reg_rsp_o.error = 1'b1;
        end
      endcase
    end
  end

  assign dmr_mode_o = mode_q;

endmodule

`default_nettype wire

// File: hdl/hmr_top.sv
// ##########################################################################
// DMR wrapper top: distributor, lane array, checker and config registers
// ##########################################################################

`timescale 1ns/10ps
`default_nettype none

module hmr_top
  import hmr_pkg::*;
#(
  parameter int unsigned num_lanes = 4
) (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic         [data_w-1:0]          hart_base_i,
  input  lane_cmd_t    [num_lanes-1:0]       cmd_i,
  input  logic         [num_lanes-1:0]       fault_i,
  input  reg_req_t                           reg_req_i,
  output reg_rsp_t                           reg_rsp_o,
  output lane_result_t [num_lanes-1:0]       result_o,
  output logic         [num_lanes/2-1:0]     dmr_error_o
);

  logic                                   dmr_mode;
  lane_cmd_t    [num_lanes-1:0]           lane_cmd;
  logic         [num_lanes-1:0][data_w-1:0] lane_hart_id;
  lane_result_t [num_lanes-1:0]           lane_result;
  logic         [num_lanes/2-1:0]         restore;
  rf_image_t    [num_lanes/2-1:0]         restore_image;
  logic         [num_lanes/2-1:0]         mismatch;

  hmr_input_dist #(
    .num_lanes ( num_lanes )
  ) i_input_dist (
    .dmr_mode_i     ( dmr_mode     ),
    .hart_base_i    ( hart_base_i  ),
    .cmd_i          ( cmd_i        ),
    .lane_cmd_o     ( lane_cmd     ),
    .lane_hart_id_o ( lane_hart_id )
  );

  for (genvar i = 0; i < num_lanes; i++) begin : gen_lanes
    // Both lanes of a pair share one restore strobe and image
    hmr_core_lane i_lane (
      .clk_i           ( clk_i              ),
      .rst_i           ( rst_i              ),
      .cmd_i           ( lane_cmd[i]        ),
      .hart_id_i       ( lane_hart_id[i]    ),
      .fault_i         ( fault_i[i]         ),
      .restore_i       ( restore[i/2]       ),
      .restore_image_i ( restore_image[i/2] ),
      .result_o        ( lane_result[i]     )
    );
  end

  hmr_checker #(
    .num_lanes ( num_lanes )
  ) i_checker (
    .clk_i           ( clk_i         ),
    .rst_i           ( rst_i         ),
    .dmr_mode_i      ( dmr_mode      ),
    .lane_result_i   ( lane_result   ),
    .restore_o       ( restore       ),
    .restore_image_o ( restore_image ),
    .result_o        ( result_o      ),
    .dmr_error_o     ( dmr_error_o   ),
    .mismatch_o      ( mismatch      )
  );

  hmr_cfg_regs #(
    .num_lanes ( num_lanes )
  ) i_cfg_regs (
    .clk_i      ( clk_i     ),
    .rst_i      ( rst_i     ),
    .reg_req_i  ( reg_req_i ),
    .mismatch_i ( mismatch  ),
    .reg_rsp_o  ( reg_rsp_o ),
    .dmr_mode_o ( dmr_mode  )
  );

endmodule

`default_nettype wire

// File: tb/hmr_sva.sv
// ##########################################################################
// Assertions bound to the DMR checker: odd results, restore on error
// and error bits under reset
// ##########################################################################

`timescale 1ns/10ps
`default_nettype none

module hmr_sva
  import hmr_pkg::*;
#(
  parameter int unsigned num_lanes = 4
) (
  input logic                               clk_i,
  input logic                               rst_i,
  input logic                               dmr_mode_i,
  input logic         [num_lanes/2-1:0]     restore_o,
  input lane_result_t [num_lanes-1:0]       result_o,
  input logic         [num_lanes/2-1:0]     dmr_error_o
);

  for (genvar p = 0; p < num_lanes / 2; p++) begin : gen_pair_chk
    // Odd output registers were cleared by the previous DMR cycle
    odd_result_invalid: assert property (@(posedge clk_i) disable iff (rst_i)
      (dmr_mode_i && $past(dmr_mode_i)) |-> !result_o[2*p+1].valid)
      else $error("odd lane %0d result valid in DMR mode", 2 * p + 1);

    // One reload per error since comparison pauses while the lanes reload
    error_has_restore: assert property (@(posedge clk_i) disable iff (rst_i)
      dmr_error_o[p] |-> restore_o[p] ##1 (!restore_o[p] && !dmr_error_o[p]))
      else $error("pair %0d error without a single restore", p);
  end

  error_clear_in_reset: assert property (@(posedge clk_i)
    rst_i |=> (dmr_error_o == '0))
    else $error("error bits set while reset is held");

endmodule

bind hmr_checker hmr_sva #(
  .num_lanes ( num_lanes )
) i_hmr_sva (
  .clk_i       ( clk_i       ),
  .rst_i       ( rst_i       ),
  .dmr_mode_i  ( dmr_mode_i  ),
  .restore_o   ( restore_o   ),
  .result_o    ( result_o    ),
  .dmr_error_o ( dmr_error_o )
);

`default_nettype wire

// File: tb/tb_hmr_top.sv
// ##########################################################################
// Directed testbench for the DMR lane wrapper: clock and reset, lane and
// register-bus drivers, lane reference model, compare tasks and watchdog
// ##########################################################################

`timescale 1ns/10ps
`default_nettype none

module tb_hmr_top
  import hmr_pkg::*;
();

  localparam int unsigned num_lanes  = 4;
  localparam int unsigned num_pairs  = num_lanes / 2;
  localparam int          clk_period = 4;
  localparam int          n_indep    = 20;
  localparam int          n_dmr      = 12;

  // Cycle budget of two cycles per lane command and one per register access
  localparam int reg_bus_cycles = 6;
  localparam int indep_cycles   = 2 * n_indep;
  localparam int hart_cycles    = 6;
  localparam int dmr_cycles     = 2 * (num_regs + n_dmr);
  localparam int fault_cycles   = 6;
  localparam int margin_cycles  = 40;
  localparam int test_cycles    = reg_bus_cycles + indep_cycles + hart_cycles
                                  + dmr_cycles + fault_cycles;

  logic                         clk;
  logic                         rst;
  logic         [data_w-1:0]    hart_base;
  lane_cmd_t    [num_lanes-1:0] cmd;
  logic         [num_lanes-1:0] fault;
  reg_req_t                     reg_req;
  reg_rsp_t                     reg_rsp;
  lane_result_t [num_lanes-1:0] result;
  logic         [num_pairs-1:0] dmr_error;

  // One register file per lane; in DMR mode the even lane holds the pair state
  logic [data_w-1:0] model_rf  [num_lanes][num_regs];
  logic [data_w-1:0] backup_rf [num_pairs][num_regs];

  int err_count;
  int check_count;
  int test_count;
  int test_start_err;

  hmr_top #(
    .num_lanes ( num_lanes )
  ) dut0 (
    .clk_i       ( clk       ),
    .rst_i       ( rst       ),
    .hart_base_i ( hart_base ),
    .cmd_i       ( cmd       ),
    .fault_i     ( fault     ),
    .reg_req_i   ( reg_req   ),
    .reg_rsp_o   ( reg_rsp   ),
    .result_o    ( result    ),
    .dmr_error_o ( dmr_error )
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(clk_period * (test_cycles + margin_cycles));
    $display("Timeout: tests still running after %0d cycles", test_cycles + margin_cycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  function automatic lane_cmd_t make_cmd(opcode_e op, logic [2:0] rd, logic [2:0] rs1,
                                         logic [2:0] rs2, logic [10:0] imm);
    lane_cmd_t c;
    c       = '0;
    c.valid = 1'b1;
    if (op == OP_LI) begin
      c.instr.i.opcode = op;
      c.instr.i.rd     = rd;
      c.instr.i.imm    = imm;
    end else begin
      c.instr.r.opcode = op;
      c.instr.r.rd     = rd;
      c.instr.r.rs1    = rs1;
      c.instr.r.rs2    = rs2;
    end
    return c;
  endfunction

  function automatic lane_cmd_t random_cmd();
    opcode_e op;
    op = opcode_e'($urandom_range(2, 0));
    return make_cmd(op, 3'($urandom), 3'($urandom), 3'($urandom), 11'($urandom));
  endfunction

  // Reference behavior of one lane command on the model register file
  function automatic lane_result_t model_step(int lane, lane_cmd_t c,
                                              logic [data_w-1:0] hart_id);
    lane_result_t r;
    logic [data_w-1:0] a;
    logic [data_w-1:0] b;
    a       = model_rf[lane][c.instr.r.rs1];
    b       = model_rf[lane][c.instr.r.rs2];
    r.valid = 1'b1;
    r.rd    = c.instr.r.rd;
    case (c.instr.r.opcode)
      OP_LI:   r.data = {21'b0, c.instr.i.imm};
      OP_ADD:  r.data = a + b;
      OP_XOR:  r.data = a ^ b;
      default: r.data = hart_id;
    endcase
    model_rf[lane][r.rd] = r.data;
    return r;
  endfunction

  function automatic reg_rsp_t rsp_of(logic [31:0] rdata, logic error);
    reg_rsp_t r;
    r.rdata = rdata;
    r.error = error;
    return r;
  endfunction

  task automatic check_result(string name, lane_result_t got, lane_result_t exp);
    check_count++;
    // Fields of an invalid result carry no meaning
    if (got.valid !== exp.valid || (exp.valid && got !== exp)) begin
      err_count++;
      $display("FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_rsp(string name, reg_rsp_t got, reg_rsp_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic test_end(string name);
    test_count++;
    if (err_count == test_start_err) begin
      $display("%s: passed", name);
    end else begin
      $display("%s: %0d errors", name, err_count - test_start_err);
    end
  endtask

  // Command cycle, idle cycle, then the registered result is visible
  task automatic apply_cmds(lane_cmd_t [num_lanes-1:0] cmds, logic [num_lanes-1:0] flt);
    cmd   = cmds;
    fault = flt;
    next_cycle();
    cmd   = '0;
    fault = '0;
    next_cycle();
  endtask

  task automatic reg_write(logic [7:0] addr, logic [31:0] data);
    reg_req.valid = 1'b1;
    reg_req.write = 1'b1;
    reg_req.addr  = addr;
    reg_req.wdata = data;
    next_cycle();
    reg_req = '0;
  endtask

  task automatic reg_read(logic [7:0] addr, output reg_rsp_t rsp);
    reg_req.valid = 1'b1;
    reg_req.write = 1'b0;
    reg_req.addr  = addr;
    reg_req.wdata = '0;
    #1;
    rsp = reg_rsp;
    next_cycle();
    reg_req = '0;
  endtask

  task automatic check_pairs(lane_cmd_t [num_lanes-1:0] cmds);
    lane_result_t exp;
    for (int p = 0; p < num_pairs; p++) begin
      exp = '0;
      if (cmds[2*p].valid) begin
        exp = model_step(2 * p, cmds[2*p], hart_base + data_w'(2 * p));
        backup_rf[p][exp.rd] = exp.data;
      end
      check_result($sformatf("result_o[%0d]", 2 * p), result[2*p], exp);
      check_bit($sformatf("result_o[%0d].valid", 2 * p + 1), result[2*p+1].valid, 1'b0);
      check_bit($sformatf("dmr_error_o[%0d]", p), dmr_error[p], 1'b0);
    end
  endtask

  task automatic test_reg_bus();
    reg_rsp_t rsp;
    test_start_err = err_count;
    reg_read(cfg_addr_count, rsp);
    check_rsp("reg_rsp_o count", rsp, rsp_of(32'd0, 1'b0));
    reg_write(cfg_addr_mode, 32'd1);
    reg_read(cfg_addr_mode, rsp);
    check_rsp("reg_rsp_o mode", rsp, rsp_of(32'd1, 1'b0));
    reg_write(cfg_addr_mode, 32'd0);
    reg_read(cfg_addr_mode, rsp);
    check_rsp("reg_rsp_o mode", rsp, rsp_of(32'd0, 1'b0));
    reg_read(8'h08, rsp);
    check_rsp("reg_rsp_o unmapped", rsp, rsp_of(32'hBADCAB1E, 1'b1));
    test_end("register bus");
  endtask

  task automatic test_independent();
    lane_cmd_t    [num_lanes-1:0] cmds;
    lane_result_t                 exp;
    test_start_err = err_count;
    for (int n = 0; n < n_indep; n++) begin
      for (int i = 0; i < num_lanes; i++) begin
        cmds[i] = random_cmd();
      end
      apply_cmds(cmds, '0);
      for (int i = 0; i < num_lanes; i++) begin
        exp = model_step(i, cmds[i], hart_base + data_w'(i));
        check_result($sformatf("result_o[%0d]", i), result[i], exp);
      end
    end
    test_end("independent lanes");
  endtask

  task automatic test_hart_ids();
    lane_cmd_t    [num_lanes-1:0] cmds;
    lane_result_t                 exp;
    test_start_err = err_count;
    hart_base = 32'h8000_0010;
    for (int i = 0; i < num_lanes; i++) begin
      cmds[i] = make_cmd(OP_HARTID, 3'd7, 3'd0, 3'd0, 11'd0);
    end
    apply_cmds(cmds, '0);
    for (int i = 0; i < num_lanes; i++) begin
      exp = model_step(i, cmds[i], hart_base + data_w'(i));
      check_result($sformatf("result_o[%0d]", i), result[i], exp);
    end
    // Odd inputs must be ignored once the pairs are locked
    reg_write(cfg_addr_mode, 32'd1);
    cmds[1] = make_cmd(OP_LI, 3'd5, 3'd0, 3'd0, 11'h7FF);
    cmds[3] = make_cmd(OP_LI, 3'd6, 3'd0, 3'd0, 11'h3A5);
    apply_cmds(cmds, '0);
    check_pairs(cmds);
    test_end("hart ids");
  endtask

  task automatic test_dmr_agree();
    lane_cmd_t [num_lanes-1:0] cmds;
    test_start_err = err_count;
    // Load every register so both lanes of a pair hold the same state
    for (int r = 0; r < num_regs; r++) begin
      for (int i = 0; i < num_lanes; i++) begin
        cmds[i] = random_cmd();
      end
      cmds[0] = make_cmd(OP_LI, 3'(r), 3'd0, 3'd0, 11'($urandom));
      cmds[2] = make_cmd(OP_LI, 3'(r), 3'd0, 3'd0, 11'($urandom));
      apply_cmds(cmds, '0);
      check_pairs(cmds);
    end
    for (int n = 0; n < n_dmr; n++) begin
      for (int i = 0; i < num_lanes; i++) begin
        cmds[i] = random_cmd();
      end
      apply_cmds(cmds, '0);
      check_pairs(cmds);
    end
    test_end("DMR agreement");
  endtask

  task automatic test_fault_recovery();
    lane_cmd_t [num_lanes-1:0] cmds;
    reg_rsp_t                  rsp;
    test_start_err = err_count;
    cmds    = '0;
    cmds[0] = make_cmd(OP_LI, 3'd3, 3'd0, 3'd0, 11'h155);
    apply_cmds(cmds, 4'b0010);
    check_result("result_o[0]", result[0], '0);
    check_bit("dmr_error_o[0]", dmr_error[0], 1'b1);
    check_bit("dmr_error_o[1]", dmr_error[1], 1'b0);
    // Pair 0 falls back to its last agreeing state
    for (int r = 0; r < num_regs; r++) begin
      model_rf[0][r] = backup_rf[0][r];
    end
    reg_read(cfg_addr_count, rsp);
    check_rsp("reg_rsp_o count", rsp, rsp_of(32'd1, 1'b0));
    cmds[0] = make_cmd(OP_ADD, 3'd4, 3'd3, 3'd3, 11'd0);
    apply_cmds(cmds, '0);
    check_pairs(cmds);
    test_end("fault and recovery");
  endtask

  initial begin
    void'($urandom(32'h6255));
    err_count      = 0;
    check_count    = 0;
    test_count     = 0;
    test_start_err = 0;
    rst            = 1'b1;
    hart_base      = 32'h0000_0100;
    cmd            = '0;
    fault          = '0;
    reg_req        = '0;
    for (int i = 0; i < num_lanes; i++) begin
      for (int r = 0; r < num_regs; r++) begin
        model_rf[i][r]      = '0;
        backup_rf[i / 2][r] = '0;
      end
    end
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    test_reg_bus();
    test_independent();
    test_hart_ids();
    test_dmr_agree();
    test_fault_recovery();
    $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
hdl/hmr_pkg.sv
hdl/hmr_core_lane.sv
hdl/hmr_input_dist.sv
hdl/hmr_checker.sv
hdl/hmr_cfg_regs.sv
hdl/hmr_top.sv
tb/hmr_sva.sv
tb/tb_hmr_top.sv

// File: run.sh
#!/bin/sh
# Build and run the DMR wrapper testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_hmr_top -Mdir obj_dir -o sim_tb -f filelist.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$log"; then
  exit 0
fi
echo "Pass message not found in $log"
exit 1
